// File: common/lsu_defines.svh
/*
  width macros for the load/store unit, shared by the package and the RTL
*/
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

////////////////////////////////////////
// bus widths
////////////////////////////////////////

`define LSU_ADDR_W 32 // byte address
`define LSU_DATA_W 32 // one bus word
`define LSU_BE_W   4  // one enable per byte lane

// byte offset inside a word, selects the lane
`define LSU_OFFS_W 2

`endif

// File: common/lsu_pkg.sv
/*
  types shared by the load/store unit blocks and the testbench
  import with lsu_pkg::* in the module header
*/
`default_nettype none

`include "lsu_defines.svh"

package lsu_pkg;

  // access size, encoding as seen on data_type_ex_i
  // 2'b11 is not named, the RTL treats it as a byte
  typedef enum logic [1:0] {
    LSU_WORD = 2'd0,
    LSU_HALF = 2'd1,
    LSU_BYTE = 2'd2
  } lsu_size_e;

  // request controller states
  typedef enum logic [1:0] {
    ST_IDLE                 = 2'd0, // nothing outstanding
    ST_WAIT_RVALID          = 2'd1, // granted, ex moved on
    ST_WAIT_RVALID_EX_STALL = 2'd2, // granted while ex stalled
    ST_IDLE_EX_STALL        = 2'd3  // data back, ex still stalled
  } lsu_state_e;

endpackage

`default_nettype wire

// File: lsu_top.f
+incdir+common
common/lsu_pkg.sv
verilog/lsu_req_format.sv
verilog/lsu_load_align.sv
verilog/lsu_ctrl_fsm.sv
verilog/lsu_top.sv
tests/tb_lsu_mem.sv
tests/tb_lsu_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the lsu testbench with verilator, exit status follows the verdict
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f lsu_top.f --top-module tb_lsu_top -Mdir obj_dir
./obj_dir/Vtb_lsu_top > sim.log 2>&1
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
  exit 1
fi
grep -q "Simulation finished: PASS" sim.log

// File: tests/tb_lsu_mem.sv
/*
  behavioral data memory for the lsu testbench, 64 bytes on a req/gnt/rvalid bus
  grant delay, response delay and error injection are supplied by the testbench
*/
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defines.svh"

module tb_lsu_mem (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   req_i,
  input  wire logic                   we_i,
  input  wire logic [`LSU_ADDR_W-1:0] addr_i,
  input  wire logic [`LSU_BE_W-1:0]   be_i,
  input  wire logic [`LSU_DATA_W-1:0] wdata_i,
  input  wire logic [1:0]             gnt_dly_i, // req cycles before gnt, 0..3
  input  wire logic [1:0]             rv_dly_i,  // gnt to rvalid, 1..3
  input  wire logic                   err_inj_i, // flag this grant as an error
  output logic                        gnt_o,
  output logic                        rvalid_o,
  output logic                        err_o,
  output logic      [`LSU_DATA_W-1:0] rdata_o
);

  logic [`LSU_DATA_W-1:0] mem [16]; // word array, addr bits 5:2
  logic [1:0]             wait_cnt;  // cycles req has waited
  logic [1:0]             rv_cnt;
  logic                   pend;      // granted, no rvalid yet
  logic [3:0]             idx;

  // start pattern, every byte differs with its full address
  function automatic logic [7:0] fill_byte(input logic [5:0] ba);
    return ({2'b00, ba} * 8'd37) ^ 8'h5b;
  endfunction

  assign idx      = addr_i[5:2];
  assign rvalid_o = pend && (rv_cnt == 2'd0);
  assign gnt_o    = req_i && (wait_cnt >= gnt_dly_i) && (!pend || rvalid_o); // one in flight
  assign err_o    = gnt_o & err_inj_i;

  ////////////////////////////////////////
  // handshake counters and storage
  ////////////////////////////////////////
  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wait_cnt <= 2'd0;
      rv_cnt   <= 2'd0;
      pend     <= 1'b0;
      rdata_o  <= '0;
      for (int ba = 0; ba < 64; ba++)
        mem[ba[5:2]][ba[1:0]*8 +: 8] <= fill_byte(ba[5:0]);
    end
    else
    begin
      if (gnt_o)
        wait_cnt <= 2'd0;
      else if (req_i && wait_cnt != 2'd3)
        wait_cnt <= wait_cnt + 2'd1; // saturates

      if (gnt_o)
      begin
        pend   <= 1'b1;
        rv_cnt <= rv_dly_i - 2'd1;
        if (!we_i)
          rdata_o <= mem[idx];
        else if (!err_inj_i) // failed stores leave memory alone
        begin
          for (int k = 0; k < 4; k++)
            if (be_i[k])
              mem[idx][k*8 +: 8] <= wdata_i[k*8 +: 8];
        end
      end
      else if (rvalid_o)
        pend <= 1'b0;
      else if (pend)
        rv_cnt <= rv_cnt - 2'd1;
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_lsu_top.sv
/*
  testbench for the load/store unit with LFSR-driven aligned loads and stores
  checked against a byte model of memory, with stall and bus protocol checks
*/
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defines.svh"

module tb_lsu_top
  import lsu_pkg::*;
();

  localparam int N_TESTS     = 400;
  localparam int WATCHDOG_NS = (N_TESTS + 2) * 10 * 100; // ten 100 ns cycles per test

  logic                   clk;
  logic                   rst_n;
  logic                   data_req_ex_i;
  logic                   data_we_ex_i;
  lsu_size_e              data_type_ex_i;
  logic                   data_sign_ext_ex_i;
  logic [`LSU_DATA_W-1:0] data_wdata_ex_i;
  logic [`LSU_ADDR_W-1:0] operand_a_ex_i;
  logic [`LSU_ADDR_W-1:0] operand_b_ex_i;
  logic                   ex_valid_i;
  logic [`LSU_DATA_W-1:0] data_rdata_ex_o;
  logic                   lsu_ready_ex_o;
  logic                   lsu_ready_wb_o;
  logic                   load_err_o;
  logic                   store_err_o;
  logic                   busy_o;
  logic                   data_req_o;
  logic                   data_gnt_i;
  logic                   data_rvalid_i;
  logic                   data_err_i;
  logic [`LSU_ADDR_W-1:0] data_addr_o;
  logic                   data_we_o;
  logic [`LSU_BE_W-1:0]   data_be_o;
  logic [`LSU_DATA_W-1:0] data_wdata_o;
  logic [`LSU_DATA_W-1:0] data_rdata_i;

  // memory responder knobs drawn once per access
  logic [1:0] gnt_dly;
  logic [1:0] rv_dly;
  logic       err_inj;

  logic [31:0]            lfsr;
  logic [7:0]             exp_mem [64]; // expected bytes
  logic [`LSU_DATA_W-1:0] held_exp;     // last load result
  logic                   cur_we;       // access now on the bus
  logic                   outstanding = 1'b0;
  int                     err_data    = 0;
  int                     err_be      = 0;
  int                     err_flag    = 0;
  int                     err_proto   = 0;

  lsu_top u_dut (.*);

  tb_lsu_mem u_mem (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_i     (data_req_o),
    .we_i      (data_we_o),
    .addr_i    (data_addr_o),
    .be_i      (data_be_o),
    .wdata_i   (data_wdata_o),
    .gnt_dly_i (gnt_dly),
    .rv_dly_i  (rv_dly),
    .err_inj_i (err_inj),
    .gnt_o     (data_gnt_i),
    .rvalid_o  (data_rvalid_i),
    .err_o     (data_err_i),
    .rdata_o   (data_rdata_i)
  );

  always #50 clk = ~clk;

  ////////////////////////////////////////
  // random source and compare tasks
  ////////////////////////////////////////
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // galois with taps 32 22 2 1
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic logic [7:0] fill_byte(input logic [5:0] ba);
    return ({2'b00, ba} * 8'd37) ^ 8'h5b; // same start pattern as the responder
  endfunction

  task automatic check_data(input string name, input logic [`LSU_DATA_W-1:0] exp,
                            input logic [`LSU_DATA_W-1:0] act);
    if (act !== exp)
    begin
      err_data++;
      $display("** Error %s: expected %h, actual %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_be(input string name, input logic [`LSU_BE_W-1:0] exp,
                          input logic [`LSU_BE_W-1:0] act);
    if (act !== exp)
    begin
      err_be++;
      $display("** Error %s: expected %b, actual %b at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      err_flag++;
      $display("** Error %s: expected %b, actual %b at %0t", name, exp, act, $time);
    end
  endtask

  // per cycle error split, request spacing and held read data
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      check_flag("load_err", data_gnt_i & data_err_i & ~cur_we, load_err_o);
      check_flag("store_err", data_gnt_i & data_err_i & cur_we, store_err_o);
      if (data_req_o && outstanding && !data_rvalid_i)
      begin
        err_proto++;
        $display("new request raised before the previous rvalid at %0t", $time);
      end
      if (data_gnt_i)
        outstanding = 1'b1;
      else if (data_rvalid_i)
        outstanding = 1'b0;
      if (!(data_rvalid_i && !cur_we))
        check_data("rdata_hold", held_exp, data_rdata_ex_o); // bypass only on load rvalid
    end
  end

  ////////////////////////////////////////
  // one access from request to idle
  ////////////////////////////////////////
  task automatic run_access();
    logic [31:0]            r;
    logic [`LSU_ADDR_W-1:0] addr;
    logic [`LSU_ADDR_W-1:0] a_op;
    logic [`LSU_DATA_W-1:0] wd;
    logic [`LSU_DATA_W-1:0] exp_wd;
    logic [`LSU_DATA_W-1:0] lane_mask;
    logic [`LSU_DATA_W-1:0] word;
    logic [`LSU_DATA_W-1:0] exp_ld;
    logic [`LSU_BE_W-1:0]   exp_be;
    logic [15:0]            h;
    logic [7:0]             b;
    lsu_size_e              sz;
    logic                   we;
    logic                   sgn;
    logic                   stall;
    logic                   err;
    logic                   done;

    take_bits(1, r);
    we = r[0];
    take_bits(2, r);
    sz = lsu_size_e'(r[1:0]); // 3 is kept and acts as a byte
    take_bits(32, r);
    addr = r;
    take_bits(32, r);
    a_op = r;
    take_bits(32, r);
    wd = r;
    take_bits(1, r);
    sgn = r[0];
    take_bits(2, r);
    stall = (r[1:0] == 2'b00); // ex frozen at grant in 1 of 4
    take_bits(2, r);
    gnt_dly <= r[1:0];
    take_bits(2, r);
    rv_dly <= (r[1:0] == 2'b00) ? 2'd1 : r[1:0];
    take_bits(4, r);
    err = (r[3:0] == 4'h0);

    if (sz == LSU_WORD)
      addr[1:0] = 2'b00;
    else if (sz == LSU_HALF)
      addr[0] = 1'b0;

    // lanes and rotated data by size and offset
    case (sz)
      LSU_WORD: exp_be = 4'b1111;
      LSU_HALF: exp_be = addr[1] ? 4'b1100 : 4'b0011;
      default:  exp_be = 4'b0001 << addr[1:0];
    endcase
    exp_wd    = '0;
    lane_mask = '0;
    for (int k = 0; k < 4; k++)
    begin
      if (exp_be[k])
      begin
        exp_wd[k*8 +: 8]    = wd[(k - addr[1:0])*8 +: 8];
        lane_mask[k*8 +: 8] = 8'hff;
      end
    end

    // expected load from the model bytes
    word = {exp_mem[{addr[5:2], 2'd3}], exp_mem[{addr[5:2], 2'd2}],
            exp_mem[{addr[5:2], 2'd1}], exp_mem[{addr[5:2], 2'd0}]};
    case (sz)
      LSU_WORD: exp_ld = word;
      LSU_HALF:
      begin
        h      = addr[1] ? word[31:16] : word[15:0];
        exp_ld = {{16{sgn & h[15]}}, h};
      end
      default:
      begin
        b      = word[addr[1:0]*8 +: 8];
        exp_ld = {{24{sgn & b[7]}}, b};
      end
    endcase

    @(posedge clk);
    data_req_ex_i      <= 1'b1;
    data_we_ex_i       <= we;
    data_type_ex_i     <= sz;
    data_sign_ext_ex_i <= sgn;
    data_wdata_ex_i    <= wd;
    operand_a_ex_i     <= a_op;
    operand_b_ex_i     <= addr - a_op; // sum lands on the chosen address
    ex_valid_i         <= ~stall;
    err_inj            <= err;
    cur_we              = we;

    // request must hold steady until the grant
    done = 1'b0;
    while (!done)
    begin
      @(negedge clk);
      check_flag("req", 1'b1, data_req_o);
      check_data("addr", addr, data_addr_o);
      check_flag("we", we, data_we_o);
      if (data_gnt_i)
        done = 1'b1;
      else
      begin
        check_flag("ready_ex_wait", 1'b0, lsu_ready_ex_o);
        @(posedge clk);
      end
    end
    check_flag("ready_ex_gnt", 1'b1, lsu_ready_ex_o);
    if (we)
    begin
      check_be("be", exp_be, data_be_o);
      check_data("wdata", exp_wd, data_wdata_o & lane_mask);
      if (!err)
      begin
        for (int k = 0; k < 4; k++)
          if (exp_be[k])
            exp_mem[{addr[5:2], k[1:0]}] = exp_wd[k*8 +: 8];
      end
    end

    @(posedge clk);
    if (!stall)
      data_req_ex_i <= 1'b0; // stalled ex keeps its request up
    done = 1'b0;
    while (!done)
    begin
      @(negedge clk);
      done = data_rvalid_i;
      if (stall)
      begin
        check_flag("stall_busy", 1'b1, busy_o);
        check_flag("stall_req", 1'b0, data_req_o);
      end
      else
        check_flag("ready_wb", done, lsu_ready_wb_o);
      if (done && !we)
      begin
        check_data("load", exp_ld, data_rdata_ex_o);
        held_exp = exp_ld;
      end
      if (!done)
        @(posedge clk);
    end

    if (stall)
    begin
      repeat (2)
      begin
        @(posedge clk);
        @(negedge clk);
        check_flag("stall_busy", 1'b1, busy_o);
        check_flag("stall_req", 1'b0, data_req_o);
      end
      @(posedge clk);
      ex_valid_i    <= 1'b1;
      data_req_ex_i <= 1'b0;
      @(negedge clk);
      check_flag("release_busy", 1'b1, busy_o); // leaves the stall state next edge
    end

    @(posedge clk);
    @(negedge clk);
    check_flag("idle_busy", 1'b0, busy_o);
    check_flag("idle_req", 1'b0, data_req_o);
    check_flag("idle_ready_ex", 1'b1, lsu_ready_ex_o);
    check_flag("idle_ready_wb", 1'b1, lsu_ready_wb_o);
  endtask

  ////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////
  initial
  begin
    clk                = 1'b0;
    rst_n              = 1'b0;
    data_req_ex_i      = 1'b0;
    data_we_ex_i       = 1'b0;
    data_type_ex_i     = LSU_WORD;
    data_sign_ext_ex_i = 1'b0;
    data_wdata_ex_i    = '0;
    operand_a_ex_i     = '0;
    operand_b_ex_i     = '0;
    ex_valid_i         = 1'b1;
    gnt_dly            = 2'd0;
    rv_dly             = 2'd1;
    err_inj            = 1'b0;
    lfsr               = 32'h8ff7;
    held_exp           = '0;
    cur_we             = 1'b0;
    for (int i = 0; i < 64; i++)
      exp_mem[i] = fill_byte(i[5:0]);

    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_flag("reset_req", 1'b0, data_req_o);
    check_flag("reset_ready_ex", 1'b1, lsu_ready_ex_o);
    check_flag("reset_ready_wb", 1'b1, lsu_ready_wb_o);
    check_flag("reset_busy", 1'b0, busy_o);

    for (int t = 0; t < N_TESTS; t++)
      run_access();

    // final memory image against the model
    for (int w = 0; w < 16; w++)
      check_data("mem_word", {exp_mem[4*w+3], exp_mem[4*w+2], exp_mem[4*w+1], exp_mem[4*w]},
                 u_mem.mem[w]);

    $display("errors: data %0d, byte enable %0d, flag %0d, protocol %0d",
             err_data, err_be, err_flag, err_proto);
    if (err_data + err_be + err_flag + err_proto == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the accesses did not complete", WATCHDOG_NS);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/lsu_ctrl_fsm.sv
/*
  request controller for the data bus, tracks one outstanding access
  produces req, the ex/wb ready signals, busy and the bus error split
*/
`timescale 1ns/1ps
`default_nettype none

module lsu_ctrl_fsm
  import lsu_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic data_req_ex_i,
  input  wire logic ex_valid_i,
  input  wire logic data_gnt_i,
  input  wire logic data_rvalid_i,
  input  wire logic data_err_i,
  input  wire logic data_we_i,
  output logic      data_req_o,
  output logic      lsu_ready_ex_o,
  output logic      lsu_ready_wb_o,
  output logic      load_err_o,
  output logic      store_err_o,
  output logic      busy_o
);

  lsu_state_e state_q;
  lsu_state_e state_d;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= ST_IDLE;
    else
      state_q <= state_d;
  end

  ////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////
  always_comb
  begin
    state_d        = state_q;
    data_req_o     = 1'b0;
    lsu_ready_ex_o = 1'b1;
    lsu_ready_wb_o = 1'b1;

    case (state_q)
      ST_IDLE:
      begin
        if (data_req_ex_i)
        begin
          data_req_o     = 1'b1;
          lsu_ready_ex_o = data_gnt_i; // held low until the grant
          if (data_gnt_i)
            state_d = ex_valid_i ? ST_WAIT_RVALID : ST_WAIT_RVALID_EX_STALL;
        end
      end

      ST_WAIT_RVALID:
      begin
        lsu_ready_wb_o = data_rvalid_i; // wb waits on the response
        if (data_rvalid_i)
        begin
          // back to back, next request may go out with this rvalid
          state_d = ST_IDLE;
          if (data_req_ex_i)
          begin
            data_req_o     = 1'b1;
            lsu_ready_ex_o = data_gnt_i;
            if (data_gnt_i)
              state_d = ex_valid_i ? ST_WAIT_RVALID : ST_WAIT_RVALID_EX_STALL;
          end
        end
      end

      ST_WAIT_RVALID_EX_STALL:
      begin
        // no new request while ex is frozen
        if (data_rvalid_i)
          state_d = ex_valid_i ? ST_IDLE : ST_IDLE_EX_STALL;
        else if (ex_valid_i)
          state_d = ST_WAIT_RVALID; // stall gone, data not yet
      end

      ST_IDLE_EX_STALL:
      begin
        if (ex_valid_i)
          state_d = ST_IDLE;
      end

      default: state_d = ST_IDLE;
    endcase
  end

  // error only valid with the grant
  assign load_err_o  = data_gnt_i & data_err_i & ~data_we_i;
  assign store_err_o = data_gnt_i & data_err_i & data_we_i;

  assign busy_o = (state_q != ST_IDLE) | data_req_o;

endmodule

`default_nettype wire

// File: verilog/lsu_load_align.sv
/*
  read path: remembers the granted access, extracts and extends load data
  drives the result in the rvalid cycle and holds it for writeback after
*/
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defines.svh"

module lsu_load_align
  import lsu_pkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   data_gnt_i,
  input  wire logic                   data_rvalid_i,
  input  wire logic                   data_we_i,
  input  wire lsu_size_e              data_type_i,
  input  wire logic                   data_sign_ext_i,
  input  wire logic [`LSU_OFFS_W-1:0] addr_offs_i,
  input  wire logic [`LSU_DATA_W-1:0] data_rdata_i,
  output logic      [`LSU_DATA_W-1:0] rdata_ex_o
);

  // attributes of the access in flight
  lsu_size_e              type_q;
  logic [`LSU_OFFS_W-1:0] offs_q;
  logic                   sign_ext_q;
  logic                   we_q;

  logic [`LSU_DATA_W-1:0] rdata_q;   // held result for wb
  logic [`LSU_DATA_W-1:0] rdata_ext; // extended load value
  logic [15:0]            half_sel;
  logic [7:0]             byte_sel;
  logic                   load_done; // rvalid belonging to a load

  ////////////////////////////////////////
  // capture at grant
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      type_q     <= LSU_WORD;
      offs_q     <= '0;
      sign_ext_q <= 1'b0;
      we_q       <= 1'b0;
    end
    else if (data_gnt_i)
    begin
      // rvalid of the previous access may share this cycle, it still sees old values
      type_q     <= data_type_i;
      offs_q     <= addr_offs_i;
      sign_ext_q <= data_sign_ext_i;
      we_q       <= data_we_i;
    end
  end

  ////////////////////////////////////////
  // lane select and extension
  ////////////////////////////////////////
  always_comb
  begin
    half_sel = offs_q[1] ? data_rdata_i[31:16] : data_rdata_i[15:0]; // bit 0 ignored
    case (offs_q)
      2'd0:    byte_sel = data_rdata_i[7:0];
      2'd1:    byte_sel = data_rdata_i[15:8];
      2'd2:    byte_sel = data_rdata_i[23:16];
      default: byte_sel = data_rdata_i[31:24];
    endcase
  end

  always_comb
  begin
    case (type_q)
      LSU_WORD: rdata_ext = data_rdata_i; // aligned word, as is
      LSU_HALF: rdata_ext = {{(`LSU_DATA_W-16){sign_ext_q & half_sel[15]}}, half_sel};
      default:  rdata_ext = {{(`LSU_DATA_W-8){sign_ext_q & byte_sel[7]}}, byte_sel};
    endcase
  end

  assign load_done = data_rvalid_i & ~we_q;

  // store responses leave the held copy alone
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rdata_q <= '0;
    else if (load_done)
      rdata_q <= rdata_ext;
  end

  assign rdata_ex_o = load_done ? rdata_ext : rdata_q; // bypass in the rvalid cycle

endmodule

`default_nettype wire

// File: verilog/lsu_req_format.sv
/*
  request formatting: address adder, byte enables and store lane rotation
  purely combinational, sits between the execute stage and the bus
*/
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defines.svh"

module lsu_req_format
  import lsu_pkg::*;
(
  input  wire logic [`LSU_ADDR_W-1:0] operand_a_i,
  input  wire logic [`LSU_ADDR_W-1:0] operand_b_i,
  input  wire lsu_size_e              data_type_i,
  input  wire logic [`LSU_DATA_W-1:0] data_wdata_i,
  output logic      [`LSU_ADDR_W-1:0] addr_o,
  output logic      [`LSU_BE_W-1:0]   be_o,
  output logic      [`LSU_DATA_W-1:0] wdata_o
);

  logic [`LSU_OFFS_W-1:0] offs; // byte lane of the address

  assign addr_o = operand_a_i + operand_b_i; // base plus offset
  assign offs   = addr_o[`LSU_OFFS_W-1:0];

  ////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////
  always_comb
  begin
    case (data_type_i)
      LSU_WORD: be_o = 4'b1111; // low bits ignored
      LSU_HALF:
      begin
        // bit 0 ignored, bit 1 picks the pair
        if (offs[1])
          be_o = 4'b1100;
        else
          be_o = 4'b0011;
      end
      default:
      begin
        // byte, also covers encoding 3
        case (offs)
          2'd0:    be_o = 4'b0001;
          2'd1:    be_o = 4'b0010;
          2'd2:    be_o = 4'b0100;
          default: be_o = 4'b1000;
        endcase
      end
    endcase
  end

  // rotate left so register byte 0 sits on the addressed lane
  always_comb
  begin
    case (offs)
      2'd0:    wdata_o = data_wdata_i;
      2'd1:    wdata_o = {data_wdata_i[23:0], data_wdata_i[31:24]};
      2'd2:    wdata_o = {data_wdata_i[15:0], data_wdata_i[31:16]};
      default: wdata_o = {data_wdata_i[7:0],  data_wdata_i[31:8]};
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/lsu_top.sv
/*
  load/store unit top, execute-stage ports on one side and the
  req/gnt/rvalid data bus on the other
*/
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defines.svh"

module lsu_top
  import lsu_pkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   rst_n,

  // execute stage
  input  wire logic                   data_req_ex_i,
  input  wire logic                   data_we_ex_i,
  input  wire lsu_size_e              data_type_ex_i,
  input  wire logic                   data_sign_ext_ex_i,
  input  wire logic [`LSU_DATA_W-1:0] data_wdata_ex_i,
  input  wire logic [`LSU_ADDR_W-1:0] operand_a_ex_i,
  input  wire logic [`LSU_ADDR_W-1:0] operand_b_ex_i,
  input  wire logic                   ex_valid_i,     // ex moves on this cycle
  output logic      [`LSU_DATA_W-1:0] data_rdata_ex_o,
  output logic                        lsu_ready_ex_o,
  output logic                        lsu_ready_wb_o,
  output logic                        load_err_o,
  output logic                        store_err_o,
  output logic                        busy_o,

  // data memory bus
  output logic                        data_req_o,
  input  wire logic                   data_gnt_i,
  input  wire logic                   data_rvalid_i,
  input  wire logic                   data_err_i,     // only with gnt
  output logic      [`LSU_ADDR_W-1:0] data_addr_o,
  output logic                        data_we_o,
  output logic      [`LSU_BE_W-1:0]   data_be_o,
  output logic      [`LSU_DATA_W-1:0] data_wdata_o,
  input  wire logic [`LSU_DATA_W-1:0] data_rdata_i
);

  assign data_we_o = data_we_ex_i;

  ////////////////////////////////////////
  // request side
  ////////////////////////////////////////
  lsu_req_format u_req_format (
    .operand_a_i  (operand_a_ex_i),
    .operand_b_i  (operand_b_ex_i),
    .data_type_i  (data_type_ex_i),
    .data_wdata_i (data_wdata_ex_i),
    .addr_o       (data_addr_o),
    .be_o         (data_be_o),
    .wdata_o      (data_wdata_o)
  );

  lsu_ctrl_fsm u_ctrl_fsm (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_req_ex_i  (data_req_ex_i),
    .ex_valid_i     (ex_valid_i),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_err_i     (data_err_i),
    .data_we_i      (data_we_ex_i),
    .data_req_o     (data_req_o),
    .lsu_ready_ex_o (lsu_ready_ex_o),
    .lsu_ready_wb_o (lsu_ready_wb_o),
    .load_err_o     (load_err_o),
    .store_err_o    (store_err_o),
    .busy_o         (busy_o)
  );

  // response side, attributes taken from the ex inputs at grant
  lsu_load_align u_load_align (
    .clk             (clk),
    .rst_n           (rst_n),
    .data_gnt_i      (data_gnt_i),
    .data_rvalid_i   (data_rvalid_i),
    .data_we_i       (data_we_ex_i),
    .data_type_i     (data_type_ex_i),
    .data_sign_ext_i (data_sign_ext_ex_i),
    .addr_offs_i     (data_addr_o[`LSU_OFFS_W-1:0]),
    .data_rdata_i    (data_rdata_i),
    .rdata_ex_o      (data_rdata_ex_o)
  );

endmodule

`default_nettype wire
